// File: list.f
design/cpuPkg.sv
design/ctrlIf.sv
design/controlUnit.sv
design/alu.sv
design/regFile.sv
design/fetchUnit.sv
design/dataMem.sv
design/cpuTop.sv
sim/cpu_properties.sv
sim/cpuTb.sv

// File: Bender.yml
package:
  name: cpu16

sources:
  - design/cpuPkg.sv
  - design/ctrlIf.sv
  - design/controlUnit.sv
  - design/alu.sv
  - design/regFile.sv
  - design/fetchUnit.sv
  - design/dataMem.sv
  - design/cpuTop.sv
  - target: simulation
    files:
      - sim/cpu_properties.sv
      - sim/cpuTb.sv

// File: sim/cpuTb.sv
`default_nettype none

module cpuTb import cpuPkg::*; ;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NumTests = 6;
    localparam int MaxLen   = 64;
    // opcode pools per test kind
    localparam logic [44:0] PoolAluR = {5'b11010, 5'b11011, 5'b11100, 5'b11101, 5'b11110,
                                        5'b11111, 5'b11001, 5'b10010, 5'b11000};
    localparam logic [24:0] PoolMem  = {5'b10000, 5'b10001, 5'b10011, 5'b01000, 5'b01010};
    localparam logic [39:0] PoolCtl  = {5'b01100, 5'b01101, 5'b01110, 5'b01111,
                                        5'b00100, 5'b00110, 5'b01000, 5'b10010};

    logic        clk;
    logic        rstN;
    logic        loadEn;
    logic [7:0]  loadAddr;
    logic [15:0] loadData;
    logic        start;
    logic        commitEn;
    logic [2:0]  commitReg;
    logic [15:0] commitData;
    logic        storeEn;
    logic [15:0] storeAddr;
    logic [15:0] storeData;
    logic        halted;
    logic        error;

    logic [31:0] seed = 32'haec6;
    logic [15:0] prog [MaxLen];
    logic [15:0] regM [8];
    logic [15:0] memM [256];
    logic [2:0]  qReg [$];
    logic [15:0] qData [$];
    logic [15:0] qAddr [$];
    logic [15:0] qSt [$];
    logic        expErr;
    int          errors;
    int          testErr;
    int          cycles = 0;
    int          cycleLimit = 0;
    string       curName;
    int          lens [NumTests] = '{40, 40, 40, 40, 30, 1};
    string       names [NumTests] = '{"immediate", "registerAlu", "loadStore",
                                      "branchJump", "exception", "emptyProgram"};

    cpuTop DUT (
        .clk(clk), .rstN(rstN), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
        .start(start), .commitEn(commitEn), .commitReg(commitReg), .commitData(commitData),
        .storeEn(storeEn), .storeAddr(storeAddr), .storeData(storeData),
        .halted(halted), .error(error)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycleLimit) begin
            $display("timeout: the core did not halt within %0d cycles", cycleLimit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [15:0] fillWord(int i);
        return 16'(i * 40503) ^ 16'h3c5a;
    endfunction

    function automatic logic [15:0] genWord(int kind, int i, int len);
        logic [31:0] r;
        logic [4:0]  op;
        logic [10:0] f;
        int          k;
        r = nextRand();
        f = r[26:16];
        case (kind)
            2:       op = PoolAluR[5*(r[15:0] % 9) +: 5];
            3:       op = PoolMem[5*(r[15:0] % 5) +: 5];
            4:       op = PoolCtl[5*r[2:0] +: 5];
            default: op = r[3] ? {3'b101, r[1:0]} : {3'b010, r[1:0]};
        endcase
        // forward targets that never pass the final halt
        k = int'(r[11:4]) % (len - 1 - i);
        if (op[4:2] == 3'b011) begin
            f[7:0] = 8'(2 * k);
        end else if (op == 5'b00100 || op == 5'b00110) begin
            f = 11'(2 * k);
        end
        return {op, f};
    endfunction

    function automatic logic [15:0] shiftOp(logic [1:0] k, logic [15:0] v, logic [3:0] n);
        case (k)
            2'd0:    return (v << n) | (v >> (16 - n));
            2'd1:    return v << n;
            2'd2:    return (v >> n) | (v << (16 - n));
            default: return v >> n;
        endcase
    endfunction

    function automatic logic [15:0] reverse(logic [15:0] v);
        logic [15:0] o;
        for (int i = 0; i < 16; i++) begin
            o[i] = v[15-i];
        end
        return o;
    endfunction

    function automatic logic compare(logic [1:0] k, logic [15:0] x, logic [15:0] y);
        logic [16:0] s;
        s = {1'b0, x} + {1'b0, y};
        case (k)
            2'd0:    return x == y;
            2'd1:    return $signed(x) < $signed(y);
            2'd2:    return $signed(x) <= $signed(y);
            default: return s[16];
        endcase
    endfunction

    task automatic writeReg(logic [2:0] n, logic [15:0] v);
        regM[n] = v;
        qReg.push_back(n);
        qData.push_back(v);
    endtask

    // instruction-set model that fills the expected commit and store queues
    task automatic runModel(int len);
        logic [15:0] w, x, y, a, s5, z5, s8, z8, s11;
        logic [4:0]  op;
        logic [2:0]  rs, rt, rd;
        logic [1:0]  fn;
        int          idx;
        bit          done;
        idx = 0;
        done = 0;
        expErr = 0;
        for (int i = 0; i < 8; i++) begin
            regM[i] = '0;
        end
        while (!done && idx < len) begin
            w = prog[idx];
            {op, rs, rt, rd, fn} = w;
            s5 = {{11{w[4]}}, w[4:0]};
            z5 = {11'b0, w[4:0]};
            s8 = {{8{w[7]}}, w[7:0]};
            z8 = {8'b0, w[7:0]};
            s11 = {{5{w[10]}}, w[10:0]};
            x = regM[rs];
            y = regM[rt];
            a = x + s5;
            idx++;
            casez (op)
                5'b00000: done = 1;
                5'b00010: begin
                    done = 1;
                    expErr = 1;
                end
                5'b01000: writeReg(rt, x + s5);
                5'b01001: writeReg(rt, s5 - x);
                5'b01010: writeReg(rt, x ^ z5);
                5'b01011: writeReg(rt, x & ~z5);
                5'b101??: writeReg(rt, shiftOp(op[1:0], x, w[3:0]));
                5'b11010: writeReg(rd, shiftOp(fn, x, y[3:0]));
                5'b11011: writeReg(rd, fn == 0 ? x + y : fn == 1 ? y - x :
                                       fn == 2 ? x ^ y : x & ~y);
                5'b111??: writeReg(rd, {15'b0, compare(op[1:0], x, y)});
                5'b11001: writeReg(rd, reverse(x));
                5'b10010: writeReg(rs, s8);
                5'b11000: writeReg(rs, (x << 8) | z8);
                5'b10000, 5'b10011: begin
                    qAddr.push_back(a);
                    qSt.push_back(y);
                    memM[a[8:1]] = y;
                    if (op[0]) begin
                        writeReg(rs, a);
                    end
                end
                5'b10001: writeReg(rt, memM[a[8:1]]);
                5'b011??: begin
                    if (op[1:0] == 0 ? x == 0 : op[1:0] == 1 ? x != 0 :
                        op[1:0] == 2 ? x[15] : !x[15]) begin
                        idx += int'(s8) / 2;
                    end
                end
                5'b00100: idx += int'(s11) / 2;
                5'b00110: begin
                    // link is pc plus 2 with pc a byte address
                    writeReg(3'd7, 16'(2 * idx));
                    idx += int'(s11) / 2;
                end
                default: ;
            endcase
        end
    endtask

    task automatic checkValue(string what, logic [15:0] exp, logic [15:0] act);
        assert (exp === act) else begin
            $display("ERR %s %s: expected %h, actual %h", curName, what, exp, act);
            testErr++;
        end
    endtask

    task automatic resetCore();
        qReg.delete();
        qData.delete();
        qAddr.delete();
        qSt.delete();
        @(posedge clk);
        rstN <= 1'b0;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        for (int i = 0; i < 256; i++) begin
            memM[i] = fillWord(i);
            DUT.uDmem.mem[i] = memM[i];
        end
    endtask

    task automatic loadProgram(int kind, int len);
        for (int i = 0; i < len - 1; i++) begin
            prog[i] = genWord(kind, i, len);
        end
        prog[len-1] = (kind == 5) ? {OpSiic, 11'b0} : {OpHalt, 11'b0};
        for (int i = 0; i < len; i++) begin
            @(posedge clk);
            loadEn   <= 1'b1;
            loadAddr <= 8'(i);
            loadData <= prog[i];
        end
        @(posedge clk);
        loadEn <= 1'b0;
    endtask

    task automatic runAndCheck();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        while (!halted) begin
            if (commitEn) begin
                assert (qReg.size() > 0) else begin
                    $display("%s: commit to r%0d that the model does not expect",
                             curName, commitReg);
                    testErr++;
                end
                if (qReg.size() > 0) begin
                    checkValue("commit reg", 16'(qReg.pop_front()), 16'(commitReg));
                    checkValue("commit data", qData.pop_front(), commitData);
                end
            end
            if (storeEn) begin
                assert (qAddr.size() > 0) else begin
                    $display("%s: store that the model does not expect", curName);
                    testErr++;
                end
                if (qAddr.size() > 0) begin
                    checkValue("store addr", qAddr.pop_front(), storeAddr);
                    checkValue("store data", qSt.pop_front(), storeData);
                end
            end
            @(negedge clk);
        end
        // nothing may retire once halted
        repeat (3) begin
            assert (!commitEn && !storeEn) else begin
                $display("%s: commit or store after the halt", curName);
                testErr++;
            end
            @(negedge clk);
        end
        assert (qReg.size() == 0 && qAddr.size() == 0) else begin
            $display("%s: %0d commits and %0d stores never appeared", curName,
                     qReg.size(), qAddr.size());
            testErr++;
        end
        checkValue("error flag", 16'(expErr), 16'(error));
    endtask

    initial begin
        clk      = 1'b0;
        rstN     = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        start    = 1'b0;
        errors   = 0;
        for (int t = 0; t < NumTests; t++) begin
            cycleLimit += lens[t] + 50;
        end
        for (int t = 0; t < NumTests; t++) begin
            curName = names[t];
            testErr = 0;
            resetCore();
            loadProgram(t + 1, lens[t]);
            runModel(lens[t]);
            runAndCheck();
            $display("test %s: %s (%0d errors)", curName, testErr == 0 ? "ok" : "bad", testErr);
            errors += testErr;
        end
        errors += DUT.uProps.failCount;
        $display("%0d tests run, %0d errors", NumTests, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/cpu_properties.sv
`default_nettype none

module cpuProperties (
    input wire logic clk,
    input wire logic rstN,
    input wire logic start,
    input wire logic running,
    input wire logic halted,
    input wire logic error
);

    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0;

    // a start strobe while idle runs the core from the next edge
    startRuns: assert property (@(posedge clk) disable iff (!rstN)
        (start && !running && !halted) |=> running)
        else begin
            $error("start while idle did not set the core running");
            failCount++;
        end

    haltedSticky: assert property (@(posedge clk) disable iff (!rstN)
        halted |=> halted)
        else begin
            $error("halted fell without a reset");
            failCount++;
        end

    errorHalts: assert property (@(posedge clk) disable iff (!rstN)
        error |-> halted)
        else begin
            $error("error raised while the core is not halted");
            failCount++;
        end

endmodule

bind cpuTop cpuProperties uProps (
    .clk(clk), .rstN(rstN), .start(start), .running(running),
    .halted(halted), .error(error)
);

`default_nettype wire

// File: design/cpuTop.sv
`default_nettype none

module cpuTop import cpuPkg::*; #(
    parameter int Width     = cpuPkg::DataWidth,
    parameter int ImemDepth = cpuPkg::ImemDepth,
    parameter int DmemDepth = cpuPkg::DmemDepth
) (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            loadEn,
    input  logic [$clog2(ImemDepth)-1:0]    loadAddr,
    input  logic [Width-1:0]                loadData,
    input  logic                            start,
    output logic                            commitEn,
    output logic [$clog2(RegCount)-1:0]     commitReg,
    output logic [Width-1:0]                commitData,
    output logic                            storeEn,
    output logic [Width-1:0]                storeAddr,
    output logic [Width-1:0]                storeData,
    output logic                            halted,
    output logic                            error
);

    localparam int RegAw  = $clog2(RegCount);
    localparam int DmemAw = $clog2(DmemDepth);

    ctrlIf ctrl ();

    instrT            instr;
    logic [4:0]       imm5;
    logic [7:0]       imm8;
    logic [10:0]      imm11;
    logic [Width-1:0] immExt, pcPlus2, rsData, rtData, aluB, aluResult;
    logic [Width-1:0] memData, loadWord, rsRev, wbData;
    logic [RegAw-1:0] wrReg;
    logic             aluZero, aluNeg, aluCarry;
    logic             running, brCond, takeBranch, signedLt, setBit, regWe;

    controlUnit uCtrl (.instr(instr), .ctrl(ctrl));

    fetchUnit #(.Width(Width), .Depth(ImemDepth)) uFetch (
        .clk(clk), .rstN(rstN), .start(start), .loadEn(loadEn), .loadAddr(loadAddr),
        .loadData(loadData), .ctrl(ctrl), .takeBranch(takeBranch),
        .jumpTarget(aluResult), .disp(immExt), .instr(instr), .pcPlus2(pcPlus2),
        .running(running), .halted(halted), .error(error)
    );

    regFile #(.Width(Width), .Count(RegCount)) uRegs (
        .clk(clk), .rstN(rstN), .rdAddrA(instr.rs), .rdAddrB(instr.rt), .wrEn(regWe),
        .wrAddr(wrReg), .wrData(wbData), .rdDataA(rsData), .rdDataB(rtData)
    );

    assign aluB = ctrl.aluSrc ? immExt : rtData;

    alu #(.Width(Width)) uAlu (
        .a(rsData), .b(aluB), .op(ctrl.aluOp), .invA(ctrl.invA), .invB(ctrl.invB),
        .cin(ctrl.cin), .result(aluResult), .zero(aluZero), .neg(aluNeg), .carry(aluCarry)
    );

    dataMem #(.Width(Width), .Depth(DmemDepth)) uDmem (
        .clk(clk), .wrEn(storeEn), .addr(aluResult[DmemAw:1]), .wrData(rtData),
        .rdData(memData)
    );

    assign imm5  = instr.imm;
    assign imm8  = {instr.rt, instr.imm};
    assign imm11 = {instr.rs, instr.rt, instr.imm};

    always_comb begin
        unique case (ctrl.immSel)
            Imm8:    immExt = ctrl.zeroExt ? {{(Width-8){1'b0}}, imm8}
                                           : {{(Width-8){imm8[7]}}, imm8};
            Disp11:  immExt = {{(Width-11){imm11[10]}}, imm11};
            default: immExt = ctrl.zeroExt ? {{(Width-5){1'b0}}, imm5}
                                           : {{(Width-5){imm5[4]}}, imm5};
        endcase
    end

    // beqz, bnez, bltz, bgez on rs
    always_comb begin
        unique case (instr.opcode[1:0])
            2'b00: brCond = (rsData == '0);
            2'b01: brCond = (rsData != '0);
            2'b10: brCond = rsData[Width-1];
            2'b11: brCond = ~rsData[Width-1];
        endcase
    end
    assign takeBranch = ctrl.branch & brCond;

    // signs differ means no overflow check needed
    assign signedLt = (rsData[Width-1] != rtData[Width-1]) ? rsData[Width-1] : aluNeg;

    always_comb begin
        unique case (instr.opcode[1:0])
            2'b00: setBit = aluZero;
            2'b01: setBit = signedLt;
            2'b10: setBit = signedLt | aluZero;
            2'b11: setBit = aluCarry;
        endcase
    end

    always_comb begin
        for (int i = 0; i < Width; i++) begin
            rsRev[i] = rsData[Width-1-i];
        end
    end

    assign loadWord = ctrl.memRead ? memData : '0;

    always_comb begin
        if (ctrl.link) begin
            wbData = pcPlus2;
        end else if (ctrl.memToReg) begin
            wbData = loadWord;
        end else if (ctrl.setCmp) begin
            wbData = Width'(setBit);
        end else if (ctrl.btr) begin
            wbData = rsRev;
        end else if (instr.opcode == OpLbi) begin
            wbData = immExt;
        end else if (instr.opcode == OpSlbi) begin
            wbData = (rsData << 8) | immExt;
        end else begin
            wbData = aluResult;
        end
    end

    // link always targets r7
    always_comb begin
        if (ctrl.link) begin
            wrReg = RegAw'(RegCount - 1);
        end else begin
            unique case (ctrl.regDst)
                RdRs:    wrReg = instr.rs;
                RdRd:    wrReg = instr.imm.rd;
                default: wrReg = instr.rt;
            endcase
        end
    end

    assign regWe      = ctrl.regWrite & running;
    assign commitEn   = regWe;
    assign commitReg  = wrReg;
    assign commitData = wbData;

    assign storeEn   = ctrl.memWrite & running;
    assign storeAddr = aluResult;
    assign storeData = rtData;

endmodule

`default_nettype wire

// File: design/dataMem.sv
`default_nettype none

module dataMem import cpuPkg::*; #(
    parameter int Width = DataWidth,
    parameter int Depth = DmemDepth
) (
    input  logic                     clk,
    input  logic                     wrEn,
    input  logic [$clog2(Depth)-1:0] addr,
    input  logic [Width-1:0]         wrData,
    output logic [Width-1:0]         rdData
);

    logic [Width-1:0] mem [Depth];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[addr] <= wrData;
        end
    end

    // async read so ld retires in the same cycle
    assign rdData = mem[addr];

endmodule

`default_nettype wire

// File: design/fetchUnit.sv
`default_nettype none

module fetchUnit import cpuPkg::*; #(
    parameter int Width = DataWidth,
    parameter int Depth = ImemDepth
) (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     start,
    input  logic                     loadEn,
    input  logic [$clog2(Depth)-1:0] loadAddr,
    input  logic [Width-1:0]         loadData,
    ctrlIf.datapath                  ctrl,
    input  logic                     takeBranch,
    input  logic [Width-1:0]         jumpTarget,
    input  logic [Width-1:0]         disp,
    output instrT                    instr,
    output logic [Width-1:0]         pcPlus2,
    output logic                     running,
    output logic                     halted,
    output logic                     error
);

    localparam int AddrW = $clog2(Depth);

    typedef enum logic [1:0] {StIdle, StRun, StStop} runStateE;

    runStateE         state;
    logic [Width-1:0] pc;
    logic [Width-1:0] nextPc;
    instrT            imem [Depth];

    // program load only while not running
    always_ff @(posedge clk) begin
        if (loadEn && state != StRun) begin
            imem[loadAddr] <= instrT'(loadData);
        end
    end

    // pc is a byte address, one word per instruction
    assign instr   = imem[pc[AddrW:1]];
    assign pcPlus2 = pc + Width'(2);

    always_comb begin
        if (ctrl.jumpReg) begin
            nextPc = jumpTarget;
        end else if (ctrl.jump || takeBranch) begin
            // disp is imm8 for branches, disp11 for j/jal
            nextPc = pcPlus2 + disp;
        end else begin
            nextPc = pcPlus2;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= StIdle;
            pc    <= '0;
            error <= 1'b0;
        end else begin
            unique case (state)
                StIdle: begin
                    if (start) begin
                        state <= StRun;
                    end
                end
                StRun: begin
                    if (ctrl.halt || ctrl.excp) begin
                        state <= StStop;
                        error <= ctrl.excp;
                    end else begin
                        pc <= nextPc;
                    end
                end
                // frozen until reset
                StStop: ;
                default: state <= StIdle;
            endcase
        end
    end

    assign running = (state == StRun);
    assign halted  = (state == StStop);

endmodule

`default_nettype wire

// File: design/regFile.sv
`default_nettype none

module regFile import cpuPkg::*; #(
    parameter int Width = DataWidth,
    parameter int Count = RegCount
) (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic [$clog2(Count)-1:0] rdAddrA,
    input  logic [$clog2(Count)-1:0] rdAddrB,
    input  logic                     wrEn,
    input  logic [$clog2(Count)-1:0] wrAddr,
    input  logic [Width-1:0]         wrData,
    output logic [Width-1:0]         rdDataA,
    output logic [Width-1:0]         rdDataB
);

    logic [Width-1:0] regs [Count];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            regs <= '{default: '0};
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // no bypass, the write lands at the retire edge
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

endmodule

`default_nettype wire

// File: design/alu.sv
`default_nettype none

module alu import cpuPkg::*; #(
    parameter int Width = DataWidth
) (
    input  logic [Width-1:0] a,
    input  logic [Width-1:0] b,
    input  aluOpE            op,
    input  logic             invA,
    input  logic             invB,
    input  logic             cin,
    output logic [Width-1:0] result,
    output logic             zero,
    output logic             neg,
    output logic             carry
);

    localparam int ShW = $clog2(Width);

    logic [Width-1:0]   opA;
    logic [Width-1:0]   opB;
    logic [ShW-1:0]     shamt;
    logic [Width:0]     sum;
    logic [2*Width-1:0] rotLeft;
    logic [2*Width-1:0] rotRight;

    assign opA = invA ? ~a : a;
    assign opB = invB ? ~b : b;

    // shift amount from the low bits of b
    assign shamt = opB[ShW-1:0];

    // subtract and compare as a + ~b + 1
    assign sum = {1'b0, opA} + {1'b0, opB} + {{Width{1'b0}}, cin};

    // doubled operand makes rotates plain shifts
    assign rotLeft  = {opA, opA} << shamt;
    assign rotRight = {opA, opA} >> shamt;

    always_comb begin
        unique case (op)
            RotL: result = rotLeft[2*Width-1:Width];
            ShL:  result = opA << shamt;
            RotR: result = rotRight[Width-1:0];
            ShR:  result = opA >> shamt;
            Add:  result = sum[Width-1:0];
            Or:   result = opA | opB;
            Xor:  result = opA ^ opB;
            And:  result = opA & opB;
        endcase
    end

    assign carry = sum[Width];
    assign zero  = ~|result;
    assign neg   = result[Width-1];

endmodule

`default_nettype wire

// File: design/controlUnit.sv
`default_nettype none

module controlUnit import cpuPkg::*; (
    input  instrT  instr,
    ctrlIf.decoder ctrl
);

    logic a, b, c, d, e, f, g;
    logic nA, nB, nC, nD, nE, nF;
    logic imm8Sel, disp11Sel;
    logic rFmt, rsDst;

    assign {a, b, c, d, e} = instr.opcode;
    assign {f, g} = instr.imm.func;

    assign nA = ~a;
    assign nB = ~b;
    assign nC = ~c;
    assign nD = ~d;
    assign nE = ~e;
    assign nF = ~f;

    // immediate ops, loads and stores, jr/jalr target
    assign ctrl.aluSrc = (nA & b & nC) |
                         (a & nB) |
                         (nA & nB & c & e);

    assign ctrl.branch  = nA & b & c;
    assign ctrl.jump    = nA & nB & c & nE;
    assign ctrl.jumpReg = nA & nB & c & e;
    assign ctrl.link    = nA & nB & c & d;

    // branches, jr/jalr, lbi and slbi take 8 bits
    assign imm8Sel = (nA & b & c) |
                     (nA & nB & c & e) |
                     (a & nB & nC & d & nE) |
                     (a & b & nC & nD & nE);

    assign disp11Sel   = nA & nB & c & nE;
    assign ctrl.immSel = immSelE'({disp11Sel, imm8Sel});

    assign ctrl.setCmp = a & b & c;
    assign ctrl.btr    = a & b & nC & nD & e;

    // everything from 10001 upwards, I-format 1 and jal/jalr
    assign ctrl.regWrite = (a & (b | c | d | e)) |
                           (nA & b & nC) |
                           (nA & nB & c & d);

    // st and stu
    assign ctrl.memWrite = a & nB & nC & (d ~^ e);

    assign ctrl.memRead  = a & nB & nC & nD & e;
    assign ctrl.memToReg = a & nB & nC & nD & e;

    assign rFmt  = a & b & (c | d | e);
    assign rsDst = (a & nB & nC & d) |
                   (a & b & nC & nD & nE);
    assign ctrl.regDst = regDstE'({rFmt, rsDst});

    // subi, sub
    assign ctrl.invA = (b & nC & e) &
                       ((nA & nD) |
                        (a & d & nF & g));

    // andni, andn, seq, slt, sle
    assign ctrl.invB = b &
                       ((a & c & ~(d & e)) |
                        (nC & d & e &
                         (nA | (a & f & g))));

    // seq, slt, sle, subi, sub
    assign ctrl.cin = b &
                      ((a & c & ~(d & e)) |
                       (nC & e &
                        ((nA & nD) | (a & d & nF & g))));

    assign ctrl.excp = nA & nB & nC & d & nE;
    assign ctrl.halt = nA & nB & nC & nD & nE;

    // xori, andni, slbi
    assign ctrl.zeroExt = (nA & b & nC & d) |
                          (a & b & nC & nD & nE);

    // R-format func codes share the immediate forms' operations
    always_comb begin
        casez ({instr.opcode, instr.imm.func})
            7'b10100??, 7'b1101000: ctrl.aluOp = RotL;
            7'b10101??, 7'b1101001: ctrl.aluOp = ShL;
            7'b10110??, 7'b1101010: ctrl.aluOp = RotR;
            7'b10111??, 7'b1101011: ctrl.aluOp = ShR;
            7'b01010??, 7'b1101110: ctrl.aluOp = Xor;
            7'b01011??, 7'b1101111: ctrl.aluOp = And;
            default:                ctrl.aluOp = Add;
        endcase
    end

endmodule

`default_nettype wire

// File: design/ctrlIf.sv
`default_nettype none

interface ctrlIf import cpuPkg::*; ();

    aluOpE  aluOp;
    logic   aluSrc;
    logic   branch;
    logic   jump;
    logic   jumpReg;
    logic   link;
    immSelE immSel;
    logic   setCmp;
    logic   btr;
    logic   regWrite;
    logic   memWrite;
    logic   memRead;
    logic   memToReg;
    regDstE regDst;
    logic   invA;
    logic   invB;
    logic   cin;
    logic   excp;
    logic   zeroExt;
    logic   halt;

    modport decoder (
        output aluOp, aluSrc, branch, jump, jumpReg, link, immSel, setCmp, btr,
        regWrite, memWrite, memRead, memToReg, regDst, invA, invB, cin, excp,
        zeroExt, halt
    );

    modport datapath (
        input aluOp, aluSrc, branch, jump, jumpReg, link, immSel, setCmp, btr,
        regWrite, memWrite, memRead, memToReg, regDst, invA, invB, cin, excp,
        zeroExt, halt
    );

endinterface

`default_nettype wire

// File: design/cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int DataWidth = 16;
    localparam int RegCount  = 8;
    localparam int ImemDepth = 256;
    localparam int DmemDepth = 256;

    // 5-bit major opcodes
    typedef enum logic [4:0] {
        OpHalt  = 5'b00000, OpNop   = 5'b00001, OpSiic  = 5'b00010, OpRti   = 5'b00011,
        OpJ     = 5'b00100, OpJr    = 5'b00101, OpJal   = 5'b00110, OpJalr  = 5'b00111,
        OpAddi  = 5'b01000, OpSubi  = 5'b01001, OpXori  = 5'b01010, OpAndni = 5'b01011,
        OpBeqz  = 5'b01100, OpBnez  = 5'b01101, OpBltz  = 5'b01110, OpBgez  = 5'b01111,
        OpSt    = 5'b10000, OpLd    = 5'b10001, OpLbi   = 5'b10010, OpStu   = 5'b10011,
        OpRoli  = 5'b10100, OpSlli  = 5'b10101, OpRori  = 5'b10110, OpSrli  = 5'b10111,
        OpSlbi  = 5'b11000, OpBtr   = 5'b11001, OpShfR  = 5'b11010, OpAluR  = 5'b11011,
        OpSeq   = 5'b11100, OpSlt   = 5'b11101, OpSle   = 5'b11110, OpSco   = 5'b11111
    } opcodeE;

    typedef enum logic [2:0] {
        RotL = 3'b000,
        ShL  = 3'b001,
        RotR = 3'b010,
        ShR  = 3'b011,
        Add  = 3'b100,
        Or   = 3'b101,
        Xor  = 3'b110,
        And  = 3'b111
    } aluOpE;

    typedef enum logic [1:0] {
        Imm5   = 2'b00,
        Imm8   = 2'b01,
        Disp11 = 2'b10
    } immSelE;

    // destination field: bits 7:5, bits 10:8 or bits 4:2
    typedef enum logic [1:0] {
        RdRt = 2'b00,
        RdRs = 2'b01,
        RdRd = 2'b10
    } regDstE;

    // low five bits double as imm5 and as rd/func of R-format
    typedef struct packed {
        logic [2:0] rd;
        logic [1:0] func;
    } rFieldT;

    typedef struct packed {
        opcodeE     opcode;
        logic [2:0] rs;
        logic [2:0] rt;
        rFieldT     imm;
    } instrT;

endpackage

`default_nettype wire
